// File: Makefile
# Verilator simulation of the target-side core

VERILATOR ?= verilator
TOP       ?= tb_cw_target
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

# Pass only when the pass message appears on a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/cw_reg_pkg.sv
`default_nettype none

package cw_reg_pkg;

   localparam int REG_ADDR_W = 6;   // Register address bits
   localparam int REG_BCNT_W = 8;   // Byte counter bits

   // Internal register bus, one request per host strobe
   typedef struct packed {
      logic [REG_ADDR_W-1:0] addr;
      logic [REG_BCNT_W-1:0] bytecnt;   // Byte index inside register
      logic [7:0]            wdata;
      logic                  write;     // One cycle pulse
      logic                  read;      // One cycle pulse
      logic                  addrvalid;
   } reg_req_t;

   // Read data, zero from blocks not owning the address
   typedef struct packed {
      logic [7:0] rdata;
   } reg_rsp_t;

   // Host parallel port pins, strobes active low
   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] wdata;
      logic       ale_n;
      logic       ce_n;
      logic       rd_n;
      logic       wr_n;
   } usb_pins_t;

   localparam logic [REG_ADDR_W-1:0] ADDR_TRIG_CFG      = 6'd8;    // 2 bytes
   localparam logic [REG_ADDR_W-1:0] ADDR_TARGET_CTL    = 6'd9;    // 1 byte
   localparam logic [REG_ADDR_W-1:0] ADDR_GLITCH_OFFSET = 6'd25;   // 2 bytes, LSB first
   localparam logic [REG_ADDR_W-1:0] ADDR_GLITCH_WIDTH  = 6'd26;   // 1 byte
   localparam logic [REG_ADDR_W-1:0] ADDR_GLITCH_CTL    = 6'd27;   // 1 byte

   // Bit positions in ADDR_TARGET_CTL
   localparam int TCTL_NPOWER_BIT   = 0;
   localparam int TCTL_AVRPROG_BIT  = 1;
   localparam int TCTL_NRST_EN_BIT  = 2;
   localparam int TCTL_NRST_VAL_BIT = 3;

   // Bit positions in ADDR_GLITCH_CTL
   localparam int GCTL_ARM_BIT   = 0;
   localparam int GCTL_ROUTE_BIT = 1;   // 0 high power, 1 low power

endpackage

`default_nettype wire

// File: design/cw_target_pkg.sv
`default_nettype none

package cw_target_pkg;

   localparam int TRIG_IO_W   = 4;    // Target IO lines into trigger
   localparam int GL_OFFSET_W = 16;   // Glitch offset counter
   localparam int GL_WIDTH_W  = 8;    // Glitch width register

   // How enabled IO lines are combined
   typedef enum logic [1:0] {
      TRIG_OR   = 2'd0,
      TRIG_AND  = 2'd1,
      TRIG_NAND = 2'd2
   } trig_mode_e;

   // Glitch generator FSM
   typedef enum logic [1:0] {
      GL_IDLE   = 2'd0,
      GL_ARMED  = 2'd1,   // Waiting for trigger
      GL_OFFSET = 2'd2,   // Counting delay
      GL_PULSE  = 2'd3    // Output active
   } glitch_state_e;

   // Target power, reset and programming controls
   typedef struct packed {
      logic npower;     // 1 powers target off
      logic avrprog;    // SPI programming pass-through
      logic nrst_en;    // Drive reset pin from nrst_val
      logic nrst_val;
   } target_ctl_t;

endpackage

`default_nettype wire

// File: design/cw_target_top.sv
`timescale 1ns/1ps
`default_nettype none

module cw_target_top (
   input  wire                                clk_usb_buf,
   input  wire                                rst_n_i,
   input  wire cw_reg_pkg::usb_pins_t         usb_i,
   output logic [7:0]                         usb_data_o,
   output logic                               usb_data_oe_o,
   input  wire [cw_target_pkg::TRIG_IO_W-1:0] target_io_i,
   input  wire                                usb_spi_mosi_i,
   input  wire                                usb_spi_sck_i,
   input  wire                                usb_treset_i,
   input  wire                                target_miso_i,
   input  wire                                ext_miso_i,
   output logic                               usb_spi_miso_o,
   output logic                               trigger_out_o,
   output logic                               glitch_hp_o,
   output logic                               glitch_lp_o,
   output logic                               target_npower_o,
   output logic                               target_drive_oe_o,
   output logic                               target_mosi_o,
   output logic                               target_sck_o,
   output logic                               target_nrst_o,
   output logic                               target_nrst_oe_o
);

   cw_reg_pkg::reg_req_t req;
   cw_reg_pkg::reg_rsp_t rsp_ctl, rsp_gl;   // Per block read data
   cw_reg_pkg::reg_rsp_t rsp;
   logic                 trig;

   // Unowned addresses return zero, so OR merges cleanly
   assign rsp = cw_reg_pkg::reg_rsp_t'(rsp_ctl | rsp_gl);

   usb_reg_bridge u_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_i         (usb_i),
      .rsp_i         (rsp),
      .req_o         (req),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o)
   );

   target_port_ctl u_port (
      .clk_usb_buf (clk_usb_buf), .rst_n_i (rst_n_i),
      .req_i (req), .rsp_o (rsp_ctl),
      .target_io_i (target_io_i),
      .usb_spi_mosi_i (usb_spi_mosi_i), .usb_spi_sck_i (usb_spi_sck_i),
      .usb_treset_i (usb_treset_i),
      .target_miso_i (target_miso_i), .ext_miso_i (ext_miso_i),
      .trig_o (trig),
      .target_npower_o (target_npower_o), .target_drive_oe_o (target_drive_oe_o),
      .target_mosi_o (target_mosi_o), .target_sck_o (target_sck_o),
      .target_nrst_o (target_nrst_o), .target_nrst_oe_o (target_nrst_oe_o),
      .usb_spi_miso_o (usb_spi_miso_o)
   );

   glitch_pulse_gen u_glitch (
      .clk_usb_buf (clk_usb_buf), .rst_n_i (rst_n_i),
      .req_i (req), .rsp_o (rsp_gl),
      .trig_i (trig),   // Same trigger the host sees
      .glitch_hp_o (glitch_hp_o), .glitch_lp_o (glitch_lp_o)
   );

   assign trigger_out_o = trig;

endmodule

`default_nettype wire

// File: design/glitch_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module glitch_pulse_gen (
   input  wire                       clk_usb_buf,
   input  wire                       rst_n_i,
   input  wire cw_reg_pkg::reg_req_t req_i,
   output cw_reg_pkg::reg_rsp_t      rsp_o,
   input  wire                       trig_i,
   output logic                      glitch_hp_o,
   output logic                      glitch_lp_o
);

   logic [cw_target_pkg::GL_OFFSET_W-1:0] offset_q;
   logic [cw_target_pkg::GL_WIDTH_W-1:0]  width_q;
   logic                                  arm_q;
   logic                                  route_q;   // Selects low power output

   cw_target_pkg::glitch_state_e          state_q;
   logic [cw_target_pkg::GL_OFFSET_W-1:0] cnt_q;     // Shared delay and width count
   logic                                  wr_en;

   assign wr_en = req_i.write && req_i.addrvalid;

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         state_q  <= cw_target_pkg::GL_IDLE;
         cnt_q    <= '0;
         arm_q    <= 1'b0;
         route_q  <= 1'b0;
         offset_q <= '0;
         width_q  <= '0;
      end else begin
         case (state_q)
            cw_target_pkg::GL_IDLE:
               if (arm_q) state_q <= cw_target_pkg::GL_ARMED;
            cw_target_pkg::GL_ARMED: begin
               if (!arm_q) begin
                  state_q <= cw_target_pkg::GL_IDLE;   // Host disarmed
               end else if (trig_i) begin
                  if (offset_q != '0) begin
                     state_q <= cw_target_pkg::GL_OFFSET;
                     cnt_q   <= offset_q - 1'b1;
                  end else if (width_q != '0) begin
                     state_q <= cw_target_pkg::GL_PULSE;   // No delay
                     cnt_q   <= {8'h00, width_q - 1'b1};
                  end else begin
                     state_q <= cw_target_pkg::GL_IDLE;
                     arm_q   <= 1'b0;
                  end
               end
            end
            cw_target_pkg::GL_OFFSET: begin
               if (cnt_q != '0) begin
                  cnt_q <= cnt_q - 1'b1;
               end else if (width_q != '0) begin
                  state_q <= cw_target_pkg::GL_PULSE;
                  cnt_q   <= {8'h00, width_q - 1'b1};
               end else begin
                  state_q <= cw_target_pkg::GL_IDLE;   // Zero width, no pulse
                  arm_q   <= 1'b0;
               end
            end
            cw_target_pkg::GL_PULSE: begin
               if (cnt_q != '0) begin
                  cnt_q <= cnt_q - 1'b1;
               end else begin
                  state_q <= cw_target_pkg::GL_IDLE;
                  arm_q   <= 1'b0;   // One shot
               end
            end
            default: state_q <= cw_target_pkg::GL_IDLE;
         endcase

         // Host writes win over the FSM clearing arm
         if (wr_en) begin
            case (req_i.addr)
               cw_reg_pkg::ADDR_GLITCH_OFFSET: begin
                  if (req_i.bytecnt == 8'd0) offset_q[7:0] <= req_i.wdata;
                  if (req_i.bytecnt == 8'd1) offset_q[15:8] <= req_i.wdata;
               end
               cw_reg_pkg::ADDR_GLITCH_WIDTH: width_q <= req_i.wdata;
               cw_reg_pkg::ADDR_GLITCH_CTL: begin
                  arm_q   <= req_i.wdata[cw_reg_pkg::GCTL_ARM_BIT];
                  route_q <= req_i.wdata[cw_reg_pkg::GCTL_ROUTE_BIT];
               end
               default: ;
            endcase
         end
      end
   end

   // Readback, arm shows live state
   always_comb begin
      rsp_o = '0;
      if (req_i.addrvalid) begin
         case (req_i.addr)
            cw_reg_pkg::ADDR_GLITCH_OFFSET: begin
               if (req_i.bytecnt == 8'd0) rsp_o.rdata = offset_q[7:0];
               if (req_i.bytecnt == 8'd1) rsp_o.rdata = offset_q[15:8];
            end
            cw_reg_pkg::ADDR_GLITCH_WIDTH:
               if (req_i.bytecnt == 8'd0) rsp_o.rdata = width_q;
            cw_reg_pkg::ADDR_GLITCH_CTL:
               if (req_i.bytecnt == 8'd0) begin
                  rsp_o.rdata[cw_reg_pkg::GCTL_ARM_BIT]   = arm_q;
                  rsp_o.rdata[cw_reg_pkg::GCTL_ROUTE_BIT] = route_q;
               end
            default: ;
         endcase
      end
   end

   assign glitch_hp_o = (state_q == cw_target_pkg::GL_PULSE) && !route_q;
   assign glitch_lp_o = (state_q == cw_target_pkg::GL_PULSE) && route_q;

   // Zero width never reaches the pulse state
   a_no_zero_width: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      $rose(state_q == cw_target_pkg::GL_PULSE) |-> $past(width_q) != '0);

   // End of pulse disarms unless the host rewrote control
   a_pulse_disarms: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      $fell(state_q == cw_target_pkg::GL_PULSE) |-> !arm_q || $past(wr_en));

endmodule

`default_nettype wire

// File: design/target_port_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module target_port_ctl (
   input  wire                                   clk_usb_buf,
   input  wire                                   rst_n_i,
   input  wire cw_reg_pkg::reg_req_t             req_i,
   output cw_reg_pkg::reg_rsp_t                  rsp_o,
   input  wire [cw_target_pkg::TRIG_IO_W-1:0]    target_io_i,
   input  wire                                   usb_spi_mosi_i,
   input  wire                                   usb_spi_sck_i,
   input  wire                                   usb_treset_i,
   input  wire                                   target_miso_i,
   input  wire                                   ext_miso_i,
   output logic                                  trig_o,
   output logic                                  target_npower_o,
   output logic                                  target_drive_oe_o,
   output logic                                  target_mosi_o,
   output logic                                  target_sck_o,
   output logic                                  target_nrst_o,
   output logic                                  target_nrst_oe_o,
   output logic                                  usb_spi_miso_o
);

   logic [cw_target_pkg::TRIG_IO_W-1:0] trig_mask_q;   // IO enable mask
   cw_target_pkg::trig_mode_e           trig_mode_q;
   cw_target_pkg::target_ctl_t          tctl_q;

   logic [cw_target_pkg::TRIG_IO_W-1:0] io_s1, io_s2;   // Two flop sync
   logic [cw_target_pkg::TRIG_IO_W-1:0] io_en;
   logic                                trig_and;
   logic                                trig_next;

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         trig_mask_q <= '0;
         trig_mode_q <= cw_target_pkg::TRIG_OR;
         tctl_q      <= '{npower: 1'b1, default: 1'b0};   // Target starts unpowered
      end else if (req_i.write && req_i.addrvalid) begin
         case (req_i.addr)
            cw_reg_pkg::ADDR_TRIG_CFG: begin
               if (req_i.bytecnt == 8'd0) trig_mask_q <= req_i.wdata[3:0];
               if (req_i.bytecnt == 8'd1) begin
                  trig_mode_q <= cw_target_pkg::trig_mode_e'(req_i.wdata[1:0]);
               end
            end
            cw_reg_pkg::ADDR_TARGET_CTL: begin
               tctl_q.npower   <= req_i.wdata[cw_reg_pkg::TCTL_NPOWER_BIT];
               tctl_q.avrprog  <= req_i.wdata[cw_reg_pkg::TCTL_AVRPROG_BIT];
               tctl_q.nrst_en  <= req_i.wdata[cw_reg_pkg::TCTL_NRST_EN_BIT];
               tctl_q.nrst_val <= req_i.wdata[cw_reg_pkg::TCTL_NRST_VAL_BIT];
            end
            default: ;
         endcase
      end
   end

   // Readback, unused bits zero
   always_comb begin
      rsp_o = '0;
      if (req_i.addrvalid) begin
         if (req_i.addr == cw_reg_pkg::ADDR_TRIG_CFG && req_i.bytecnt == 8'd0) begin
            rsp_o.rdata = {4'h0, trig_mask_q};
         end else if (req_i.addr == cw_reg_pkg::ADDR_TRIG_CFG && req_i.bytecnt == 8'd1) begin
            rsp_o.rdata = {6'h00, trig_mode_q};
         end else if (req_i.addr == cw_reg_pkg::ADDR_TARGET_CTL && req_i.bytecnt == 8'd0) begin
            rsp_o.rdata[cw_reg_pkg::TCTL_NPOWER_BIT]   = tctl_q.npower;
            rsp_o.rdata[cw_reg_pkg::TCTL_AVRPROG_BIT]  = tctl_q.avrprog;
            rsp_o.rdata[cw_reg_pkg::TCTL_NRST_EN_BIT]  = tctl_q.nrst_en;
            rsp_o.rdata[cw_reg_pkg::TCTL_NRST_VAL_BIT] = tctl_q.nrst_val;
         end
      end
   end

   assign io_en    = io_s2 & trig_mask_q;
   assign trig_and = &(io_s2 | ~trig_mask_q);   // Masked lines count as high

   always_comb begin
      trig_next = 1'b0;
      if (trig_mask_q != '0) begin   // Empty mask never triggers
         case (trig_mode_q)
            cw_target_pkg::TRIG_OR:   trig_next = |io_en;
            cw_target_pkg::TRIG_AND:  trig_next = trig_and;
            cw_target_pkg::TRIG_NAND: trig_next = !trig_and;
            default:                  trig_next = 1'b0;
         endcase
      end
   end

   // Sync then register, trigger moves three edges after IO
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         io_s1  <= '0;
         io_s2  <= '0;
         trig_o <= 1'b0;
      end else begin
         io_s1  <= target_io_i;
         io_s2  <= io_s1;
         trig_o <= trig_next;
      end
   end

   assign target_npower_o   = tctl_q.npower;
   assign target_drive_oe_o = !tctl_q.npower && tctl_q.avrprog;   // MOSI and SCK
   assign target_mosi_o     = usb_spi_mosi_i;
   assign target_sck_o      = usb_spi_sck_i;
   assign target_nrst_o     = tctl_q.avrprog ? usb_treset_i : tctl_q.nrst_val;
   assign target_nrst_oe_o  = !tctl_q.npower && (tctl_q.avrprog || tctl_q.nrst_en);
   assign usb_spi_miso_o    = tctl_q.avrprog ? target_miso_i : ext_miso_i;

   // Power-off write leaves only high-impedance pins on the next cycle
   a_off_no_drive: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      req_i.write && req_i.addrvalid && req_i.addr == cw_reg_pkg::ADDR_TARGET_CTL &&
      req_i.wdata[cw_reg_pkg::TCTL_NPOWER_BIT]
      |=> !(target_drive_oe_o || target_nrst_oe_o));

endmodule

`default_nettype wire

// File: design/usb_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module usb_reg_bridge (
   input  wire                        clk_usb_buf,
   input  wire                        rst_n_i,
   input  wire cw_reg_pkg::usb_pins_t usb_i,
   input  wire cw_reg_pkg::reg_rsp_t  rsp_i,
   output cw_reg_pkg::reg_req_t       req_o,
   output logic [7:0]                 usb_data_o,
   output logic                       usb_data_oe_o
);

   cw_reg_pkg::usb_pins_t usb_q;   // Pins sampled once

   logic wr_qq, rd_qq;   // Previous strobe samples for edge detect
   logic wr_fall;
   logic rd_fall;
   logic rd_rise;        // Host released rd_n with data still out
   logic rd_done;        // Delays byte count after read

   logic [cw_reg_pkg::REG_ADDR_W-1:0] addr_q;
   logic [cw_reg_pkg::REG_BCNT_W-1:0] bcnt_q;
   logic [7:0]                        wdata_q;
   logic                              write_q;
   logic                              read_q;
   logic                              addrvalid_q;

   assign wr_fall = !usb_q.wr_n && wr_qq && !usb_q.ce_n;
   assign rd_fall = !usb_q.rd_n && rd_qq && !usb_q.ce_n;
   assign rd_rise = usb_q.rd_n && usb_data_oe_o;

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         usb_q         <= '1;   // Strobes idle high
         wr_qq         <= 1'b1;
         rd_qq         <= 1'b1;
         write_q       <= 1'b0;
         read_q        <= 1'b0;
         rd_done       <= 1'b0;
         usb_data_oe_o <= 1'b0;
         addr_q        <= '0;
         bcnt_q        <= '0;
         addrvalid_q   <= 1'b0;
      end else begin
         usb_q   <= usb_i;
         wr_qq   <= usb_q.wr_n;
         rd_qq   <= usb_q.rd_n;
         write_q <= wr_fall;   // Single cycle pulses
         read_q  <= rd_fall;
         rd_done <= rd_rise;

         if (rd_fall) begin
            usb_data_oe_o <= 1'b1;
         end else if (rd_rise) begin
            usb_data_oe_o <= 1'b0;   // Release bus once host lets go
         end

         // Address phase restarts the byte counter
         if (!usb_q.ale_n && !usb_q.ce_n) begin
            addr_q      <= usb_q.addr[cw_reg_pkg::REG_ADDR_W-1:0];
            bcnt_q      <= '0;
            addrvalid_q <= 1'b1;
         end else if (write_q || rd_done) begin
            bcnt_q <= bcnt_q + 1'b1;   // Step to next byte
         end
      end
   end

   // Data held for host until rd_n rises again
   always_ff @(posedge clk_usb_buf) begin
      if (wr_fall) wdata_q <= usb_q.wdata;
      if (rd_fall) usb_data_o <= rsp_i.rdata;
   end

   assign req_o = '{
      addr:      addr_q,
      bytecnt:   bcnt_q,
      wdata:     wdata_q,
      write:     write_q,
      read:      read_q,
      addrvalid: addrvalid_q
   };

   // Host never overlaps strobes
   a_no_rw_overlap: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(write_q && read_q));

endmodule

`default_nettype wire

// File: test/tb_cw_target.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cw_target;

   localparam int CLK_NS       = 20;
   localparam int RESET_BUDGET = 20;     // Cycle budgets per test
   localparam int REG_BUDGET   = 400;
   localparam int TRIG_BUDGET  = 800;
   localparam int PINS_BUDGET  = 200;
   localparam int GL_BUDGET    = 1500;   // Offsets kept under 40
   localparam int WATCHDOG_NS  =
      2 * (RESET_BUDGET + REG_BUDGET + TRIG_BUDGET + PINS_BUDGET + GL_BUDGET) * CLK_NS;

   logic                  clk_usb_buf = 1'b0;
   logic                  rst_n_i;
   cw_reg_pkg::usb_pins_t usb_pins;      // Host port, strobes active low
   logic [7:0]            usb_data_o;
   logic                  usb_data_oe_o;
   logic [3:0]            target_io_i;
   logic                  usb_spi_mosi_i, usb_spi_sck_i, usb_treset_i;
   logic                  target_miso_i, ext_miso_i, usb_spi_miso_o;
   logic                  trigger_out_o, glitch_hp_o, glitch_lp_o;
   logic                  target_npower_o, target_drive_oe_o, target_mosi_o;
   logic                  target_sck_o, target_nrst_o, target_nrst_oe_o;

   int          error_count = 0;
   int          check_count = 0;

   always #(CLK_NS / 2) clk_usb_buf = ~clk_usb_buf;

   cw_target_top dut (.usb_i (usb_pins), .*);

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      check_count++;
      assert (actual == expected) else begin
         $display("Fail time %0d ns %s expected %0h actual %0h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   // Address phase, ce_n stays low afterwards
   task automatic latch_address(input logic [cw_reg_pkg::REG_ADDR_W-1:0] addr);
      @(negedge clk_usb_buf);
      usb_pins.addr  = {2'b00, addr};
      usb_pins.ale_n = 1'b0;
      usb_pins.ce_n  = 1'b0;
      repeat (3) @(negedge clk_usb_buf);
      usb_pins.ale_n = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
   endtask

   task automatic write_byte(input logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_pins.wdata = data;
      usb_pins.wr_n  = 1'b0;
      repeat (3) @(negedge clk_usb_buf);   // Minimum strobe width
      usb_pins.wr_n = 1'b1;
      repeat (3) @(negedge clk_usb_buf);   // Byte count steps here
   endtask

   task automatic read_byte(output logic [7:0] data);
      int held;
      @(negedge clk_usb_buf);
      usb_pins.rd_n = 1'b0;
      held = 0;
      while (!usb_data_oe_o && held < 6) begin   // oe marks valid data
         @(negedge clk_usb_buf);
         held++;
      end
      check_value("usb_data_oe_o", 16'h0001, 16'(usb_data_oe_o));
      data = usb_data_o;
      while (held < 3) begin
         @(negedge clk_usb_buf);
         held++;
      end
      usb_pins.rd_n = 1'b1;
      repeat (4) @(negedge clk_usb_buf);
      check_value("usb_data_oe_o", 16'h0000, 16'(usb_data_oe_o));   // Bus released
   endtask

   // Little endian, byte count picks the byte
   task automatic write_register(input logic [cw_reg_pkg::REG_ADDR_W-1:0] addr,
                                 input logic [15:0] data, input int nbytes);
      latch_address(addr);
      for (int i = 0; i < nbytes; i++) write_byte(data[8*i +: 8]);
   endtask

   task automatic read_register(input logic [cw_reg_pkg::REG_ADDR_W-1:0] addr,
                                input int nbytes, output logic [15:0] data);
      logic [7:0] b;
      data = 16'h0000;
      latch_address(addr);
      for (int i = 0; i < nbytes; i++) begin
         read_byte(b);
         data[8*i +: 8] = b;
      end
   endtask

   function automatic logic trig_expected(input logic [3:0] io, input logic [3:0] mask,
                                          input cw_target_pkg::trig_mode_e mode);
      logic all_high;
      all_high = ((io & mask) == mask);
      if (mask == 4'h0) return 1'b0;   // Nothing enabled
      case (mode)
         cw_target_pkg::TRIG_OR:   return |(io & mask);
         cw_target_pkg::TRIG_AND:  return all_high;
         cw_target_pkg::TRIG_NAND: return !all_high;
         default:                  return 1'b0;
      endcase
   endfunction

   task automatic reset_state();
      check_value("trigger_out_o", 16'h0000, 16'(trigger_out_o));
      check_value("glitch_hp_o", 16'h0000, 16'(glitch_hp_o));
      check_value("glitch_lp_o", 16'h0000, 16'(glitch_lp_o));
      check_value("usb_data_oe_o", 16'h0000, 16'(usb_data_oe_o));
      check_value("target_drive_oe_o", 16'h0000, 16'(target_drive_oe_o));
      check_value("target_nrst_oe_o", 16'h0000, 16'(target_nrst_oe_o));
      check_value("target_npower_o", 16'h0001, 16'(target_npower_o));   // Unpowered
   endtask

   task automatic register_access();
      logic [15:0] trig_cfg, offset, rd;
      logic [7:0]  tctl, width, gctl;
      trig_cfg = 16'($urandom);
      offset   = 16'($urandom);
      tctl     = 8'($urandom);
      width    = 8'($urandom);
      gctl     = 8'($urandom);
      gctl[cw_reg_pkg::GCTL_ARM_BIT] = 1'b0;   // Keep generator idle
      write_register(cw_reg_pkg::ADDR_TRIG_CFG, trig_cfg, 2);
      write_register(cw_reg_pkg::ADDR_TARGET_CTL, {8'h00, tctl}, 1);
      write_register(cw_reg_pkg::ADDR_GLITCH_OFFSET, offset, 2);
      write_register(cw_reg_pkg::ADDR_GLITCH_WIDTH, {8'h00, width}, 1);
      write_register(cw_reg_pkg::ADDR_GLITCH_CTL, {8'h00, gctl}, 1);
      read_register(cw_reg_pkg::ADDR_TRIG_CFG, 2, rd);
      check_value("trig_cfg", trig_cfg & 16'h030F, rd);   // Mask nibble, 2 bit mode
      read_register(cw_reg_pkg::ADDR_TARGET_CTL, 1, rd);
      check_value("target_ctl", {8'h00, tctl & 8'h0F}, rd);
      read_register(cw_reg_pkg::ADDR_GLITCH_OFFSET, 2, rd);
      check_value("glitch_offset", offset, rd);
      read_register(cw_reg_pkg::ADDR_GLITCH_WIDTH, 1, rd);
      check_value("glitch_width", {8'h00, width}, rd);
      read_register(cw_reg_pkg::ADDR_GLITCH_CTL, 1, rd);
      check_value("glitch_ctl", {8'h00, gctl & 8'h03}, rd);
      read_register(6'd3, 1, rd);   // Unmapped
      check_value("usb_data_o", 16'h0000, rd);
      write_register(cw_reg_pkg::ADDR_TARGET_CTL, 16'h0001, 1);   // Back to powered off
   endtask

   task automatic trigger_combine();
      cw_target_pkg::trig_mode_e mode_list [3];
      logic [3:0]                mask;
      logic [3:0]                io;
      logic                      prev;
      mode_list[0] = cw_target_pkg::TRIG_OR;
      mode_list[1] = cw_target_pkg::TRIG_AND;
      mode_list[2] = cw_target_pkg::TRIG_NAND;
      foreach (mode_list[m]) begin
         for (int i = 0; i < 4; i++) begin
            mask = (i == 0) ? 4'h0 : 4'($urandom_range(15, 1));   // First mask empty
            write_register(cw_reg_pkg::ADDR_TRIG_CFG, {6'h00, mode_list[m], 4'h0, mask}, 2);
            prev = trig_expected(target_io_i, mask, mode_list[m]);
            check_value("trigger_out_o", 16'(prev), 16'(trigger_out_o));
            for (int p = 0; p < 6; p++) begin
               io = 4'($urandom);
               @(negedge clk_usb_buf);
               target_io_i = io;
               repeat (2) @(negedge clk_usb_buf);
               check_value("trigger_out_o", 16'(prev), 16'(trigger_out_o));   // Not yet
               @(negedge clk_usb_buf);
               prev = trig_expected(io, mask, mode_list[m]);
               check_value("trigger_out_o", 16'(prev), 16'(trigger_out_o));
            end
         end
      end
      @(negedge clk_usb_buf);
      target_io_i = 4'h0;
      write_register(cw_reg_pkg::ADDR_TRIG_CFG, 16'h0000, 2);
   endtask

   task automatic pins_case(input logic npower, input logic avrprog,
                            input logic nrst_en, input logic nrst_val);
      logic [7:0] ctl;
      logic [4:0] pins;
      logic       drive_exp;
      logic       nrst_oe_exp;
      ctl = 8'h00;
      ctl[cw_reg_pkg::TCTL_NPOWER_BIT]   = npower;
      ctl[cw_reg_pkg::TCTL_AVRPROG_BIT]  = avrprog;
      ctl[cw_reg_pkg::TCTL_NRST_EN_BIT]  = nrst_en;
      ctl[cw_reg_pkg::TCTL_NRST_VAL_BIT] = nrst_val;
      write_register(cw_reg_pkg::ADDR_TARGET_CTL, {8'h00, ctl}, 1);
      if (npower) begin   // Unpowered target, all pins released
         drive_exp   = 1'b0;
         nrst_oe_exp = 1'b0;
      end else if (avrprog) begin
         drive_exp   = 1'b1;
         nrst_oe_exp = 1'b1;
      end else begin
         drive_exp   = 1'b0;
         nrst_oe_exp = nrst_en;   // Reset pin only
      end
      for (int i = 0; i < 4; i++) begin
         pins = 5'($urandom);
         @(negedge clk_usb_buf);
         {ext_miso_i, target_miso_i, usb_treset_i, usb_spi_sck_i, usb_spi_mosi_i} = pins;
         @(negedge clk_usb_buf);
         check_value("target_npower_o", 16'(npower), 16'(target_npower_o));
         check_value("target_drive_oe_o", 16'(drive_exp), 16'(target_drive_oe_o));
         check_value("target_nrst_oe_o", 16'(nrst_oe_exp), 16'(target_nrst_oe_o));
         check_value("usb_spi_miso_o", 16'(avrprog ? pins[3] : pins[4]), 16'(usb_spi_miso_o));
         if (drive_exp) begin
            check_value("target_mosi_o", 16'(pins[0]), 16'(target_mosi_o));
            check_value("target_sck_o", 16'(pins[1]), 16'(target_sck_o));
         end
         if (nrst_oe_exp) begin
            check_value("target_nrst_o", 16'(avrprog ? pins[2] : nrst_val), 16'(target_nrst_o));
         end
      end
   endtask

   task automatic target_pins();
      pins_case(1'b1, 1'b1, 1'b1, 1'($urandom));   // Power off overrides all
      pins_case(1'b0, 1'b1, 1'b0, 1'($urandom));   // ISP pass-through
      pins_case(1'b0, 1'b0, 1'b1, 1'b0);
      pins_case(1'b0, 1'b0, 1'b1, 1'b1);
      pins_case(1'b0, 1'b0, 1'b0, 1'b1);           // Reset pin released
      pins_case(1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   // Width zero runs the same path and must stay quiet
   task automatic glitch_pulse(input int offset, input int width, input logic route);
      logic [7:0]  ctl;
      logic [15:0] rd;
      logic        exp_on;
      int          waited;
      ctl = 8'h00;
      ctl[cw_reg_pkg::GCTL_ARM_BIT]   = 1'b1;
      ctl[cw_reg_pkg::GCTL_ROUTE_BIT] = route;
      write_register(cw_reg_pkg::ADDR_TRIG_CFG, {6'h00, cw_target_pkg::TRIG_OR, 8'h01}, 2);
      write_register(cw_reg_pkg::ADDR_GLITCH_OFFSET, 16'(offset), 2);
      write_register(cw_reg_pkg::ADDR_GLITCH_WIDTH, 16'(width), 1);
      write_register(cw_reg_pkg::ADDR_GLITCH_CTL, {8'h00, ctl}, 1);
      @(negedge clk_usb_buf);
      target_io_i = 4'h1;
      waited = 0;
      while (!trigger_out_o && waited < 8) begin
         @(negedge clk_usb_buf);
         waited++;
      end
      assert (trigger_out_o) else begin
         $display("Trigger output never rose after raising target IO 0");
         error_count++;
      end
      for (int k = 1; k <= offset + width + 3; k++) begin   // k edges after trigger
         @(negedge clk_usb_buf);
         exp_on = (k > offset) && (k <= offset + width);
         check_value("glitch_hp_o", 16'(exp_on && !route), 16'(glitch_hp_o));
         check_value("glitch_lp_o", 16'(exp_on && route), 16'(glitch_lp_o));
      end
      target_io_i = 4'h0;
      ctl[cw_reg_pkg::GCTL_ARM_BIT] = 1'b0;   // One shot clears arm
      read_register(cw_reg_pkg::ADDR_GLITCH_CTL, 1, rd);
      check_value("glitch_ctl", {8'h00, ctl}, rd);
   endtask

   task automatic glitch_tests();
      for (int i = 0; i < 6; i++) begin
         glitch_pulse(int'($urandom_range(39, 0)), int'($urandom_range(20, 1)), 1'($urandom));
      end
      glitch_pulse(int'($urandom_range(39, 0)), 0, 1'($urandom));
   endtask

   initial begin
      void'($urandom(32'hc5f2));
      usb_pins       = '{addr: 8'h00, wdata: 8'h00, default: 1'b1};   // Strobes idle
      target_io_i    = 4'h0;
      usb_spi_mosi_i = 1'b0;
      usb_spi_sck_i  = 1'b0;
      usb_treset_i   = 1'b1;
      target_miso_i  = 1'b0;
      ext_miso_i     = 1'b0;
      rst_n_i        = 1'b0;
      repeat (8) @(negedge clk_usb_buf);
      rst_n_i = 1'b1;
      @(negedge clk_usb_buf);
      reset_state();
      register_access();
      trigger_combine();
      target_pins();
      glitch_tests();
      $display("checks %0d errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all tests finished");
      $display("checks %0d errors %0d", check_count, error_count + 1);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
design/cw_reg_pkg.sv
design/cw_target_pkg.sv
design/usb_reg_bridge.sv
design/target_port_ctl.sv
design/glitch_pulse_gen.sv
design/cw_target_top.sv
test/tb_cw_target.sv
